/* common/snake_pkg.sv */
package snake_pkg;

    localparam int coord_width = 10;   // Screen counter width

    // Horizontal timing in pixels
    localparam logic [coord_width-1:0] h_total      = 10'd800;
    localparam logic [coord_width-1:0] h_active     = 10'd640;
    localparam logic [coord_width-1:0] h_sync_start = 10'd656;
    localparam logic [coord_width-1:0] h_sync_end   = 10'd752;

    // Vertical timing in lines
    localparam logic [coord_width-1:0] v_total      = 10'd525;
    localparam logic [coord_width-1:0] v_active     = 10'd480;
    localparam logic [coord_width-1:0] v_sync_start = 10'd490;
    localparam logic [coord_width-1:0] v_sync_end   = 10'd492;

    localparam int block_size  = 5;     // Pixels per block side
    localparam int grid_cols   = 124;
    localparam int grid_rows   = 81;
    localparam int block_width = 7;     // Block coordinate width
    localparam int max_length   = 16;   // Segment table capacity
    localparam int length_width = 5;    // Holds 0..16

    localparam logic [coord_width-1:0] area_x0 = 10'd58;
    localparam logic [coord_width-1:0] area_y0 = 10'd43;
    // First pixel past the playfield on each axis
    localparam logic [coord_width-1:0] area_x_end = coord_width'(58 + grid_cols * block_size);
    localparam logic [coord_width-1:0] area_y_end = coord_width'(43 + grid_rows * block_size);

    typedef enum logic [2:0] {none, head, body, tail, fruit} figure_kind;

    // 5x5 sprites, pixel 0 in bits 49:48, one 10-bit group per row
    localparam logic [49:0] sprite_head = {10'b00_10_10_10_00, 10'b10_11_10_11_10,
        10'b10_10_10_10_10, 10'b10_10_10_10_10, 10'b00_10_10_10_00};
    localparam logic [49:0] sprite_body = {10'b00_01_01_01_00, 10'b01_01_10_01_01,
        10'b01_10_01_10_01, 10'b01_01_10_01_01, 10'b00_01_01_01_00};
    localparam logic [49:0] sprite_tail = {10'b00_00_01_00_00, 10'b00_01_01_01_00,
        10'b01_01_01_01_01, 10'b00_01_01_01_00, 10'b00_00_01_00_00};
    localparam logic [49:0] sprite_fruit = {10'b00_00_01_00_00, 10'b00_11_11_11_00,
        10'b11_11_10_11_11, 10'b11_11_11_11_11, 10'b00_11_11_11_00};

    // RGB 3-3-2 colors
    localparam logic [7:0] palette_1    = 8'h1C;   // Green
    localparam logic [7:0] palette_2    = 8'hFC;   // Yellow
    localparam logic [7:0] palette_3    = 8'hE0;   // Red
    localparam logic [7:0] color_field  = 8'h04;
    localparam logic [7:0] color_border = 8'hB6;
    localparam logic [7:0] color_blank  = 8'h00;

endpackage

/* design/vga_timing.sv */
module vga_timing (
    input  logic                                clock_25,
    input  logic                                reset,
    output logic [snake_pkg::coord_width-1:0]   pixel_x,
    output logic [snake_pkg::coord_width-1:0]   pixel_y,
    output logic                                frame_start
);

    logic line_end;
    logic frame_end;

    assign line_end  = (pixel_x == snake_pkg::h_total - 1'b1);
    assign frame_end = (pixel_y == snake_pkg::v_total - 1'b1);

    // Pixel counter along the line
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            pixel_x <= '0;
        end else if (line_end) begin
            pixel_x <= '0;
        end else begin
            pixel_x <= pixel_x + 1'b1;
        end
    end

    // Line counter, steps once per line
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            pixel_y <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                pixel_y <= '0;
            end else begin
                pixel_y <= pixel_y + 1'b1;
            end
        end
    end

    // One cycle long, while both counters sit at the origin
    assign frame_start = (pixel_x == '0) && (pixel_y == '0);

endmodule

/* snake_input/segment_loader.sv */
module segment_loader (
    input  logic                                clock_25,
    input  logic                                reset,
    input  logic [snake_pkg::block_width-1:0]   seg_x,
    input  logic [snake_pkg::block_width-1:0]   seg_y,
    input  logic                                seg_last,
    input  logic                                seg_req,
    output logic                                seg_ack,
    input  logic [snake_pkg::block_width-1:0]   fruit_x,
    input  logic [snake_pkg::block_width-1:0]   fruit_y,
    input  logic                                frame_start,
    output logic [snake_pkg::block_width-1:0]   snake_x [snake_pkg::max_length],
    output logic [snake_pkg::block_width-1:0]   snake_y [snake_pkg::max_length],
    output logic [snake_pkg::length_width-1:0]  snake_length,
    output logic [snake_pkg::block_width-1:0]   shown_fruit_x,
    output logic [snake_pkg::block_width-1:0]   shown_fruit_y
);

    typedef enum logic {idle, wait_release} load_state;

    load_state                          state;
    logic [snake_pkg::length_width-1:0] write_index;     // Saturates at max_length
    logic [snake_pkg::length_width-1:0] pending_length;
    logic [snake_pkg::block_width-1:0]  pending_x [snake_pkg::max_length];
    logic [snake_pkg::block_width-1:0]  pending_y [snake_pkg::max_length];
    logic                               has_room;

    assign has_room = int'(write_index) < snake_pkg::max_length;

    // Handshake FSM and pending length
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state          <= idle;
            seg_ack        <= 1'b0;
            write_index    <= '0;
            pending_length <= '0;
        end else begin
            case (state)
                idle: if (seg_req) begin
                    seg_ack <= 1'b1;
                    state   <= wait_release;
                    if (seg_last) begin
                        // Entry count, dropped extras not included
                        pending_length <= has_room ? write_index + 1'b1 : write_index;
                        write_index    <= '0;
                    end else if (has_room) begin
                        write_index <= write_index + 1'b1;
                    end
                end
                wait_release: if (!seg_req) begin
                    seg_ack <= 1'b0;
                    state   <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock_25) begin
        if (state == idle && seg_req && has_room) begin
            pending_x[write_index[3:0]] <= seg_x;
            pending_y[write_index[3:0]] <= seg_y;
        end
    end

    // Frame start commit of the list and fruit
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            snake_length <= '0;            // Nothing drawn before the first list
        end else if (frame_start) begin
            snake_length <= pending_length;
        end
    end

    always_ff @(posedge clock_25) begin
        if (frame_start) begin
            snake_x       <= pending_x;
            snake_y       <= pending_y;
            shown_fruit_x <= fruit_x;
            shown_fruit_y <= fruit_y;
        end
    end

endmodule

/* graphic/block_tracker.sv */
module block_tracker (
    input  logic                                clock_25,
    input  logic                                reset,
    input  logic [snake_pkg::coord_width-1:0]   pixel_x,
    input  logic [snake_pkg::coord_width-1:0]   pixel_y,
    output logic [snake_pkg::block_width-1:0]   block_col,
    output logic [snake_pkg::block_width-1:0]   block_row,
    output logic [2:0]                          offset_x,
    output logic [2:0]                          offset_y,
    output logic                                in_area
);

    logic x_inside;
    logic y_inside;
    logic last_x;    // Last pixel column of a block
    logic last_y;

    assign x_inside = (pixel_x >= snake_pkg::area_x0) && (pixel_x < snake_pkg::area_x_end);
    assign y_inside = (pixel_y >= snake_pkg::area_y0) && (pixel_y < snake_pkg::area_y_end);
    assign last_x   = (offset_x == 3'(snake_pkg::block_size - 1));
    assign last_y   = (offset_y == 3'(snake_pkg::block_size - 1));

    // Column tracking, restarts at the left edge of the playfield
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            block_col <= '0;
            offset_x  <= '0;
        end else if (pixel_x == snake_pkg::area_x0) begin
            block_col <= '0;
            offset_x  <= '0;
        end else if (x_inside) begin
            if (last_x) begin
                block_col <= block_col + 1'b1;
                offset_x  <= '0;
            end else begin
                offset_x <= offset_x + 1'b1;
            end
        end
    end

    // Row tracking, steps once per line at the line boundary
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            block_row <= '0;
            offset_y  <= '0;
        end else if (pixel_x == '0) begin
            if (pixel_y == snake_pkg::area_y0) begin
                block_row <= '0;
                offset_y  <= '0;
            end else if (y_inside) begin
                if (last_y) begin
                    block_row <= block_row + 1'b1;
                    offset_y  <= '0;
                end else begin
                    offset_y <= offset_y + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            in_area <= 1'b0;
        end else begin
            in_area <= x_inside && y_inside;
        end
    end

endmodule

/* graphic/figure_match.sv */
module figure_match (
    input  logic                                clock_25,
    input  logic                                reset,
    input  logic [snake_pkg::block_width-1:0]   block_col,
    input  logic [snake_pkg::block_width-1:0]   block_row,
    input  logic [2:0]                          offset_x,
    input  logic [2:0]                          offset_y,
    input  logic                                in_area,
    input  logic [snake_pkg::block_width-1:0]   snake_x [snake_pkg::max_length],
    input  logic [snake_pkg::block_width-1:0]   snake_y [snake_pkg::max_length],
    input  logic [snake_pkg::length_width-1:0]  snake_length,
    input  logic [snake_pkg::block_width-1:0]   shown_fruit_x,
    input  logic [snake_pkg::block_width-1:0]   shown_fruit_y,
    output snake_pkg::figure_kind               figure,
    output logic [4:0]                          offset_index
);

    logic head_hit;
    logic tail_hit;
    logic body_hit;
    logic fruit_hit;

    // Every live entry compared at once
    always_comb begin
        head_hit = 1'b0;
        tail_hit = 1'b0;
        body_hit = 1'b0;
        for (int i = 0; i < snake_pkg::max_length; i++) begin
            if (i < int'(snake_length) && snake_x[i] == block_col
                    && snake_y[i] == block_row) begin
                if (i == 0) begin
                    head_hit = 1'b1;
                end else if (i == int'(snake_length) - 1) begin
                    tail_hit = 1'b1;                 // Only reachable with length 2 or more
                end else begin
                    body_hit = 1'b1;
                end
            end
        end
    end

    // Fruit hidden until a list has been committed
    assign fruit_hit = (snake_length != '0) && (shown_fruit_x == block_col)
        && (shown_fruit_y == block_row);

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            figure       <= snake_pkg::none;
            offset_index <= '0;
        end else begin
            offset_index <= {offset_y, 2'b00} + offset_y + offset_x;   // offset_y*5 + offset_x
            if (!in_area) begin
                figure <= snake_pkg::none;
            end else if (head_hit) begin
                figure <= snake_pkg::head;
            end else if (tail_hit) begin
                figure <= snake_pkg::tail;
            end else if (fruit_hit) begin
                figure <= snake_pkg::fruit;
            end else if (body_hit) begin
                figure <= snake_pkg::body;
            end else begin
                figure <= snake_pkg::none;
            end
        end
    end

endmodule

/* graphic/sprite_rom.sv */
module sprite_rom (
    input  snake_pkg::figure_kind figure,
    output logic [49:0]           sprite
);

    // Sprite lookup by figure kind
    always_comb begin
        case (figure)
            snake_pkg::head:  sprite = snake_pkg::sprite_head;
            snake_pkg::body:  sprite = snake_pkg::sprite_body;
            snake_pkg::tail:  sprite = snake_pkg::sprite_tail;
            snake_pkg::fruit: sprite = snake_pkg::sprite_fruit;
            default:          sprite = '0;   // Empty block, all field color
        endcase
    end

endmodule

/* design/pixel_output.sv */
module pixel_output (
    input  logic                                clock_25,
    input  logic                                reset,
    input  logic [49:0]                         sprite,
    input  logic [4:0]                          offset_index,
    input  logic                                in_area,
    input  logic [snake_pkg::coord_width-1:0]   pixel_x,
    input  logic [snake_pkg::coord_width-1:0]   pixel_y,
    output logic [7:0]                          rgb,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                active
);

    logic [snake_pkg::coord_width-1:0] pixel_x_mid;
    logic [snake_pkg::coord_width-1:0] pixel_y_mid;
    logic [snake_pkg::coord_width-1:0] pixel_x_late;   // Aligned with the figure stage
    logic [snake_pkg::coord_width-1:0] pixel_y_late;
    logic                              in_area_late;
    logic [5:0]                        code_msb;
    logic [1:0]                        code;
    logic                              visible;
    logic [7:0]                        color;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            pixel_x_mid  <= '0;
            pixel_y_mid  <= '0;
            pixel_x_late <= '0;
            pixel_y_late <= '0;
            in_area_late <= 1'b0;
        end else begin
            pixel_x_mid  <= pixel_x;
            pixel_y_mid  <= pixel_y;
            pixel_x_late <= pixel_x_mid;
            pixel_y_late <= pixel_y_mid;
            in_area_late <= in_area;
        end
    end

    assign code_msb = 6'd49 - {offset_index, 1'b0};   // Pixel 0 in the top bits
    assign code     = sprite[code_msb -: 2];
    assign visible  = (pixel_x_late < snake_pkg::h_active) && (pixel_y_late < snake_pkg::v_active);

    always_comb begin
        if (!visible) begin
            color = snake_pkg::color_blank;
        end else if (!in_area_late) begin
            color = snake_pkg::color_border;
        end else begin
            case (code)
                2'd1:    color = snake_pkg::palette_1;
                2'd2:    color = snake_pkg::palette_2;
                2'd3:    color = snake_pkg::palette_3;
                default: color = snake_pkg::color_field;
            endcase
        end
    end

    // Syncs are active low
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            rgb    <= '0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            active <= 1'b0;
        end else begin
            rgb    <= color;
            hsync  <= !(pixel_x_late >= snake_pkg::h_sync_start
                && pixel_x_late < snake_pkg::h_sync_end);
            vsync  <= !(pixel_y_late >= snake_pkg::v_sync_start
                && pixel_y_late < snake_pkg::v_sync_end);
            active <= visible;
        end
    end

endmodule

/* design/snake_display_top.sv */
module snake_display_top (
    input  logic                                clock_25,
    input  logic                                reset,
    input  logic [snake_pkg::block_width-1:0]   seg_x,
    input  logic [snake_pkg::block_width-1:0]   seg_y,
    input  logic                                seg_last,
    input  logic                                seg_req,
    output logic                                seg_ack,
    input  logic [snake_pkg::block_width-1:0]   fruit_x,
    input  logic [snake_pkg::block_width-1:0]   fruit_y,
    output logic [7:0]                          rgb,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                active
);

    logic [snake_pkg::coord_width-1:0]  pixel_x;
    logic [snake_pkg::coord_width-1:0]  pixel_y;
    logic                               frame_start;
    logic [snake_pkg::block_width-1:0]  snake_x [snake_pkg::max_length];
    logic [snake_pkg::block_width-1:0]  snake_y [snake_pkg::max_length];
    logic [snake_pkg::length_width-1:0] snake_length;
    logic [snake_pkg::block_width-1:0]  shown_fruit_x;
    logic [snake_pkg::block_width-1:0]  shown_fruit_y;
    logic [snake_pkg::block_width-1:0]  block_col;
    logic [snake_pkg::block_width-1:0]  block_row;
    logic [2:0]                         offset_x;
    logic [2:0]                         offset_y;
    logic                               in_area;
    snake_pkg::figure_kind              figure;
    logic [4:0]                         offset_index;
    logic [49:0]                        sprite;

    vga_timing timing (.clock_25, .reset, .pixel_x, .pixel_y, .frame_start);

    segment_loader loader (
        .clock_25, .reset, .seg_x, .seg_y, .seg_last, .seg_req, .seg_ack,
        .fruit_x, .fruit_y, .frame_start, .snake_x, .snake_y, .snake_length,
        .shown_fruit_x, .shown_fruit_y
    );

    block_tracker tracker (
        .clock_25, .reset, .pixel_x, .pixel_y, .block_col, .block_row,
        .offset_x, .offset_y, .in_area
    );

    figure_match matcher (
        .clock_25, .reset, .block_col, .block_row, .offset_x, .offset_y, .in_area,
        .snake_x, .snake_y, .snake_length, .shown_fruit_x, .shown_fruit_y,
        .figure, .offset_index
    );

    sprite_rom rom (.figure, .sprite);

    pixel_output out_stage (
        .clock_25, .reset, .sprite, .offset_index, .in_area, .pixel_x, .pixel_y,
        .rgb, .hsync, .vsync, .active
    );

endmodule

/* bench/snake_display_tb.sv */
module snake_display_tb;

    localparam int latency        = 3;        // Counter value to registered output
    localparam int check_frames   = 5;
    localparam int frame_cycles   = int'(snake_pkg::h_total) * int'(snake_pkg::v_total);
    localparam int timeout_cycles = 6 * frame_cycles + 1000;
    localparam int area_left      = int'(snake_pkg::area_x0);
    localparam int area_top       = int'(snake_pkg::area_y0);
    localparam int area_right     = area_left + snake_pkg::grid_cols * snake_pkg::block_size;
    localparam int area_bottom    = area_top + snake_pkg::grid_rows * snake_pkg::block_size;
    localparam int table_size     = snake_pkg::max_length;

    logic                              clock_25;
    logic                              reset;
    logic [snake_pkg::block_width-1:0] seg_x;
    logic [snake_pkg::block_width-1:0] seg_y;
    logic                              seg_last;
    logic                              seg_req;
    logic                              seg_ack;
    logic [snake_pkg::block_width-1:0] fruit_x;
    logic [snake_pkg::block_width-1:0] fruit_y;
    logic [7:0]                        rgb;
    logic                              hsync;
    logic                              vsync;
    logic                              active;

    logic [31:0] rand_state;
    int          send_x [$];                 // List handed to the writer
    int          send_y [$];
    int          pend_x [table_size];        // Model of the pending table
    int          pend_y [table_size];
    int          pend_length;
    int          model_index;
    int          frame_x [8][table_size];    // List shown in each frame
    int          frame_y [8][table_size];
    int          frame_length [8];
    int          frame_fruit_x [8];
    int          frame_fruit_y [8];
    int          view_x [table_size];
    int          view_y [table_size];
    int          view_frame;
    int          cycle_index;                // Cycles since reset release
    int          total_cycles;
    int          check_pixel;
    int          check_x;
    int          check_y;
    int          want_sync;
    logic        last_ack;
    logic        last_req;                   // Request level seen at the last clock edge
    string       frame_name [check_frames] = '{"blank_start", "first_snake", "list_swap",
        "random_snake", "overflow_list"};

    snake_display_top UUT (
        .clock_25, .reset, .seg_x, .seg_y, .seg_last, .seg_req, .seg_ack,
        .fruit_x, .fruit_y, .rgb, .hsync, .vsync, .active
    );

    initial begin
        clock_25 = 1'b0;
        forever #4 clock_25 = !clock_25;
    end

    task automatic check_equal(input string test_name, input string signal_name,
            input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s %s: expected 0x%0h, actual 0x%0h at time %0t", test_name,
                signal_name, expected, actual, $time);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int random_below(input int limit);
        rand_state = xorshift(rand_state);
        return int'(rand_state % limit);
    endfunction

    // Expected color of one screen pixel for a given list and fruit
    function automatic logic [7:0] expected_rgb(input int x, input int y,
            input int list_x [table_size], input int list_y [table_size],
            input int length, input int fruit_col, input int fruit_row);
        int          col;
        int          row;
        int          index;
        int          code;
        bit          head_hit;
        bit          tail_hit;
        bit          body_hit;
        bit          fruit_hit;
        logic [49:0] sprite;
        if (x >= int'(snake_pkg::h_active) || y >= int'(snake_pkg::v_active)) begin
            return snake_pkg::color_blank;
        end
        if (x < area_left || x >= area_right || y < area_top || y >= area_bottom) begin
            return snake_pkg::color_border;
        end
        col   = (x - area_left) / snake_pkg::block_size;
        row   = (y - area_top) / snake_pkg::block_size;
        index = ((y - area_top) % snake_pkg::block_size) * snake_pkg::block_size
            + (x - area_left) % snake_pkg::block_size;
        head_hit = 1'b0;
        tail_hit = 1'b0;
        body_hit = 1'b0;
        for (int i = 0; i < length; i++) begin
            if (list_x[i] == col && list_y[i] == row) begin
                if (i == 0) head_hit = 1'b1;
                else if (i == length - 1) tail_hit = 1'b1;
                else body_hit = 1'b1;
            end
        end
        fruit_hit = (length > 0) && (fruit_col == col) && (fruit_row == row);
        if (head_hit) sprite = snake_pkg::sprite_head;
        else if (tail_hit) sprite = snake_pkg::sprite_tail;
        else if (fruit_hit) sprite = snake_pkg::sprite_fruit;
        else if (body_hit) sprite = snake_pkg::sprite_body;
        else sprite = '0;
        code = int'((sprite >> (48 - 2 * index)) & 50'd3);   // Pixel 0 in the top bits
        case (code)
            1:       return snake_pkg::palette_1;
            2:       return snake_pkg::palette_2;
            3:       return snake_pkg::palette_3;
            default: return snake_pkg::color_field;
        endcase
    endfunction

    task automatic wait_until_cycle(input int target);
        while (cycle_index < target) begin
            @(posedge clock_25);
            #1;
        end
    endtask

    task automatic random_wait();
        int n;
        n = random_below(4);
        repeat (n) begin
            @(posedge clock_25);
            #1;
        end
    endtask

    task automatic wait_for_ack(input logic level);
        while (seg_ack != level) begin
            @(posedge clock_25);
            #1;
        end
    endtask

    // Loader model, entries past the table size are dropped
    task automatic record_segment(input int x, input int y, input bit last);
        if (model_index < table_size) begin
            pend_x[model_index] = x;
            pend_y[model_index] = y;
        end
        if (last) begin
            pend_length = (model_index < table_size) ? model_index + 1 : table_size;
            model_index = 0;
        end else if (model_index < table_size) begin
            model_index++;
        end
    endtask

    // Four-phase writer for the whole queued list
    task automatic send_list(input bit use_delay);
        int count;
        count = send_x.size();
        for (int i = 0; i < count; i++) begin
            if (use_delay) random_wait();
            seg_x    = snake_pkg::block_width'(send_x[i]);
            seg_y    = snake_pkg::block_width'(send_y[i]);
            seg_last = (i == count - 1);
            seg_req  = 1'b1;
            wait_for_ack(1'b1);
            record_segment(send_x[i], send_y[i], i == count - 1);
            if (use_delay) random_wait();
            seg_req = 1'b0;
            wait_for_ack(1'b0);
        end
        seg_last = 1'b0;
    endtask

    task automatic fill_random_list();
        send_x.delete();
        send_y.delete();
        for (int i = 0; i < table_size; i++) begin
            send_x.push_back(random_below(116));    // Columns that reach the screen
            send_y.push_back(random_below(snake_pkg::grid_rows));
        end
        send_x[7]  = snake_pkg::grid_cols - 1;     // Last playfield block, off screen
        send_y[7]  = snake_pkg::grid_rows - 1;
        send_x[11] = 116;                          // Cut by the right screen edge
        send_y[11] = snake_pkg::grid_rows - 1;
        send_x[9]  = send_x[0];                    // Body under the head
        send_y[9]  = send_y[0];
        send_x[15] = send_x[3];                    // Tail over a body block
        send_y[15] = send_y[3];
        fruit_x = snake_pkg::block_width'(send_x[5]);
        fruit_y = snake_pkg::block_width'(send_y[5]);
    endtask

    // Display table model, loaded when the counters pass 0,0
    always @(posedge clock_25) begin
        if (reset) begin
            if (cycle_index % frame_cycles == 0 && cycle_index / frame_cycles < 8) begin
                for (int i = 0; i < table_size; i++) begin
                    frame_x[cycle_index / frame_cycles][i] = pend_x[i];
                    frame_y[cycle_index / frame_cycles][i] = pend_y[i];
                end
                frame_length[cycle_index / frame_cycles]  = pend_length;
                frame_fruit_x[cycle_index / frame_cycles] = int'(fruit_x);
                frame_fruit_y[cycle_index / frame_cycles] = int'(fruit_y);
            end
            cycle_index++;
        end
    end

    always @(negedge clock_25) begin
        if (reset && cycle_index >= latency
                && cycle_index - latency < check_frames * frame_cycles) begin
            check_pixel = cycle_index - latency;
            check_x     = check_pixel % int'(snake_pkg::h_total);
            check_y     = (check_pixel / int'(snake_pkg::h_total)) % int'(snake_pkg::v_total);
            if (check_pixel / frame_cycles != view_frame) begin
                view_frame = check_pixel / frame_cycles;
                for (int i = 0; i < table_size; i++) begin
                    view_x[i] = frame_x[view_frame][i];
                    view_y[i] = frame_y[view_frame][i];
                end
            end
            check_equal(frame_name[view_frame], "rgb", int'(expected_rgb(check_x, check_y,
                view_x, view_y, frame_length[view_frame], frame_fruit_x[view_frame],
                frame_fruit_y[view_frame])), int'(rgb));
            want_sync = (check_x >= int'(snake_pkg::h_sync_start)
                && check_x < int'(snake_pkg::h_sync_end)) ? 0 : 1;
            check_equal(frame_name[view_frame], "hsync", want_sync, int'(hsync));
            want_sync = (check_y >= int'(snake_pkg::v_sync_start)
                && check_y < int'(snake_pkg::v_sync_end)) ? 0 : 1;
            check_equal(frame_name[view_frame], "vsync", want_sync, int'(vsync));
            check_equal(frame_name[view_frame], "active", (check_x < int'(snake_pkg::h_active)
                && check_y < int'(snake_pkg::v_active)) ? 1 : 0, int'(active));
        end
    end

    // Ack edges must follow the request level at the clock edge that moved them
    always @(negedge clock_25) begin
        if (reset && seg_ack && !last_ack) begin
            check_equal("handshake", "req at ack rise", 1, int'(last_req));
        end
        if (reset && !seg_ack && last_ack) begin
            check_equal("handshake", "req at ack fall", 0, int'(last_req));
        end
        last_ack = seg_ack;
        last_req = seg_req;
    end

    always @(posedge clock_25) begin
        total_cycles++;
        if (total_cycles > timeout_cycles) begin
            $display("Run did not finish within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        reset        = 1'b0;
        seg_x        = '0;
        seg_y        = '0;
        seg_last     = 1'b0;
        seg_req      = 1'b0;
        fruit_x      = 7'd10;          // Inside the field, hidden while the length is 0
        fruit_y      = 7'd10;
        rand_state   = 32'd62307;
        pend_length  = 0;
        model_index  = 0;
        view_frame   = -1;
        cycle_index  = 0;
        total_cycles = 0;
        last_ack     = 1'b0;
        last_req     = 1'b0;
        for (int i = 0; i < table_size; i++) begin
            pend_x[i] = 0;
            pend_y[i] = 0;
        end
        repeat (15) @(posedge clock_25);
        #1;
        check_equal("reset_state", "rgb", 0, int'(rgb));
        check_equal("reset_state", "hsync", 1, int'(hsync));
        check_equal("reset_state", "vsync", 1, int'(vsync));
        check_equal("reset_state", "active", 0, int'(active));
        check_equal("reset_state", "seg_ack", 0, int'(seg_ack));
        @(posedge clock_25);
        #1;
        reset = 1'b1;
        // Length 5 snake, shown from frame 1
        send_x  = '{20, 21, 22, 22, 22};
        send_y  = '{10, 10, 10, 11, 12};
        fruit_x = 7'd30;
        fruit_y = 7'd15;
        send_list(1'b0);
        // New list halfway through frame 1, on rows the scan has not reached yet
        wait_until_cycle(frame_cycles + frame_cycles / 2);
        send_x  = '{40, 40, 40, 41, 42};
        send_y  = '{60, 61, 62, 62, 62};
        fruit_x = 7'd5;
        fruit_y = 7'd70;
        send_list(1'b1);
        wait_until_cycle(2 * frame_cycles + frame_cycles / 2);
        fill_random_list();
        send_list(1'b1);
        // Same list plus a 17th segment that must be dropped
        wait_until_cycle(3 * frame_cycles + frame_cycles / 2);
        send_x.push_back(60);
        send_y.push_back(60);
        send_list(1'b1);
        wait_until_cycle(check_frames * frame_cycles + latency);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* vlog.f */
common/snake_pkg.sv
design/vga_timing.sv
snake_input/segment_loader.sv
graphic/block_tracker.sv
graphic/figure_match.sv
graphic/sprite_rom.sv
design/pixel_output.sv
design/snake_display_top.sv
bench/snake_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the snake display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module snake_display_tb -o sim_snake
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

./obj_dir/sim_snake > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
